//--- mem_subsys_testdata.txt
// client op addr len data opaque expected_read_data (hex; op 1 write, 0 read)
// client 0 uses 0x0010-0x001f, client 1 uses 0x0100-0x010f; last line is the latency probe
0 1 0010 0 11223344 01 00000000
0 0 0010 0 00000000 02 11223344
0 1 0014 0 aabbccdd 03 00000000
0 1 0014 1 00000055 04 00000000
0 0 0014 0 00000000 05 aabbcc55
0 1 0018 0 01020304 06 00000000
0 1 0018 2 0000beef 07 00000000
0 0 0018 1 00000000 08 0102beef
0 1 001c 0 cafef00d 09 00000000
0 1 001c 3 00123456 0a 00000000
0 0 001c 0 00000000 0b ca123456
1 1 0100 0 deadbeef 81 00000000
1 0 0100 0 00000000 82 deadbeef
1 1 0104 0 55aa55aa 83 00000000
1 1 0104 3 00778899 84 00000000
1 0 0104 3 00000000 85 55778899
1 1 0108 0 87654321 86 00000000
1 1 0108 1 000000ff 87 00000000
1 0 0108 0 00000000 88 876543ff
1 1 0108 2 00001234 89 00000000
1 0 0108 0 00000000 8a 87651234
0 0 0010 0 00000000 c0 11223344

//--- flist.f
mem_cfg_pkg.sv
mem_msg_pkg.sv
mem_if.sv
mem_resp_fifo.sv
mem_server.sv
mem_req_arbiter.sv
mem_subsys_top.sv
mem_subsys_checker.sv
tb_mem_subsys.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile the memory subsystem testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_mem_subsys -f flist.f -o tb_sim \
  || { echo "Build failed"; exit 1; }

sim_out="$(./obj_dir/tb_sim)"
echo "$sim_out"

echo "$sim_out" | grep -qx "Test passed" && echo "PASS" || { echo "FAIL"; exit 1; }

//--- tb_mem_subsys.sv
// Memory subsystem testbench
// Two file-driven clients with random response stalls, model-based checks,
// round-robin grant tracking and a lone-request latency probe

`timescale 1ns/100ps

module tb_mem_subsys import mem_cfg_pkg::*; import mem_msg_pkg::*; ();

  localparam int DELAY   = 2;
  localparam int DEPTH   = 4;
  localparam int N_LINES = 22;
  localparam int N_COLS  = 7;
  // Cycle budget for the whole run
  localparam int LIMIT   = 20 * N_LINES + 200;

  logic      clk;
  logic      rst = 1'b1;

  // Client side signals, index is the client
  logic      req_val   [2] = '{default: 1'b0};
  logic      req_rdy   [2];
  mem_op_e   req_op    [2] = '{default: MEM_READ};
  mem_addr_t req_addr  [2] = '{default: '0};
  mem_len_t  req_len   [2] = '{default: '0};
  mem_data_t req_data  [2] = '{default: '0};
  mem_opq_t  req_opq   [2] = '{default: '0};
  logic      resp_val  [2];
  logic      resp_rdy  [2] = '{default: 1'b1};
  mem_op_e   resp_op   [2];
  mem_addr_t resp_addr [2];
  mem_len_t  resp_len  [2];
  mem_data_t resp_data [2];
  mem_opq_t  resp_opq  [2];

  // Raw file words and the decoded lines
  logic [31:0] td [N_LINES*N_COLS];
  int        ln_client [N_LINES];
  mem_op_e   ln_op     [N_LINES];
  mem_addr_t ln_addr   [N_LINES];
  mem_len_t  ln_len    [N_LINES];
  mem_data_t ln_data   [N_LINES];
  mem_opq_t  ln_opq    [N_LINES];
  mem_data_t ln_rdata  [N_LINES];

  // Model state, one memory per client
  mem_data_t model_mem [2][DEF_MEM_WORDS];
  mem_data_t pred_data [N_LINES];
  int        acc_cyc   [N_LINES];

  // Lines waiting to be sent, and lines waiting for a response
  int   pend     [2][N_LINES];
  int   pend_wr  [2] = '{default: 0};
  int   pend_rd  [2] = '{default: 0};
  int   exp_line [2][N_LINES];
  int   exp_wr   [2] = '{default: 0};
  int   exp_rd   [2] = '{default: 0};
  int   cur_line [2] = '{default: 0};
  logic acc_q    [2] = '{default: 1'b0};
  logic last_gnt;

  // 0 reset, 1 traffic, 2 latency probe
  int phase       = 0;
  int cycles      = 0;
  int check_count = 0;
  int error_count = 0;
  int resp_count  = 0;
  int seed        = 96;

  mem_subsys_top #(
    .p_transac_delay (DELAY),
    .p_resp_depth    (DEPTH),
    .p_mem_words     (DEF_MEM_WORDS)
  ) dut_i (
    .clk          (clk),
    .rst          (rst),
    .c0_req_val   (req_val[0]),
    .c0_req_rdy   (req_rdy[0]),
    .c0_req_op    (req_op[0]),
    .c0_req_addr  (req_addr[0]),
    .c0_req_len   (req_len[0]),
    .c0_req_data  (req_data[0]),
    .c0_req_opq   (req_opq[0]),
    .c1_req_val   (req_val[1]),
    .c1_req_rdy   (req_rdy[1]),
    .c1_req_op    (req_op[1]),
    .c1_req_addr  (req_addr[1]),
    .c1_req_len   (req_len[1]),
    .c1_req_data  (req_data[1]),
    .c1_req_opq   (req_opq[1]),
    .c0_resp_val  (resp_val[0]),
    .c0_resp_rdy  (resp_rdy[0]),
    .c0_resp_op   (resp_op[0]),
    .c0_resp_addr (resp_addr[0]),
    .c0_resp_len  (resp_len[0]),
    .c0_resp_data (resp_data[0]),
    .c0_resp_opq  (resp_opq[0]),
    .c1_resp_val  (resp_val[1]),
    .c1_resp_rdy  (resp_rdy[1]),
    .c1_resp_op   (resp_op[1]),
    .c1_resp_addr (resp_addr[1]),
    .c1_resp_len  (resp_len[1]),
    .c1_resp_data (resp_data[1]),
    .c1_resp_opq  (resp_opq[1])
  );

  // Low len bytes of the new word replace the old ones, len 0 is all four
  function automatic mem_data_t merge_bytes(input mem_data_t old_w, input mem_data_t new_w,
                                            input mem_len_t len);
    mem_data_t w;
    int        n;
    w = old_w;
    n = (len == 2'd0) ? 4 : int'(len);
    for (int i = 0; i < n; i++) begin
      w[8*i +: 8] = new_w[8*i +: 8];
    end
    return w;
  endfunction

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] %s: got %h, expected %h", name, actual, expected);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // --------------------------------------------------
  // Request drivers, falling edge
  // --------------------------------------------------

  always @(negedge clk) begin : drive_blk
    int l;
    if (phase != 0) begin
      for (int c = 0; c < 2; c++) begin
        // About one cycle in four stalled during traffic
        resp_rdy[c] = (phase == 1) ? (($random(seed) & 3) != 0) : 1'b1;
        if (!req_val[c] || acc_q[c]) begin
          if (pend_rd[c] < pend_wr[c]) begin
            l = pend[c][pend_rd[c]];
            pend_rd[c]++;
            cur_line[c] = l;
            req_val[c]  = 1'b1;
            req_op[c]   = ln_op[l];
            req_addr[c] = ln_addr[l];
            req_len[c]  = ln_len[l];
            req_data[c] = ln_data[l];
            req_opq[c]  = ln_opq[l];
          end else begin
            req_val[c] = 1'b0;
          end
        end
      end
    end
  end

  // --------------------------------------------------
  // Monitor, rising edge
  // --------------------------------------------------

  always @(posedge clk) begin : observe_blk
    int   l;
    logic exp_gnt;
    if (rst) begin
      // Client 0 is favoured first
      last_gnt = 1'b1;
    end else if (cycles >= LIMIT) begin
      $display("Timeout after %0d cycles, only %0d of %0d responses seen",
               cycles, resp_count, N_LINES);
      $display("Checks: %0d  Errors: %0d", check_count, error_count);
      $display("Test failed");
      $finish;
    end else begin
      cycles++;
      for (int c = 0; c < 2; c++) begin
        acc_q[c] = req_val[c] && req_rdy[c];
        if (acc_q[c]) begin
          l = cur_line[c];
          acc_cyc[l] = cycles;
          if (ln_op[l] == MEM_WRITE) begin
            model_mem[c][ln_addr[l][9:2]] =
              merge_bytes(model_mem[c][ln_addr[l][9:2]], ln_data[l], ln_len[l]);
          end
          pred_data[l] = model_mem[c][ln_addr[l][9:2]];
          exp_line[c][exp_wr[c]] = l;
          exp_wr[c]++;
        end
      end
      // Contention goes to the client not granted last
      if (acc_q[0] || acc_q[1]) begin
        if (req_val[0] && req_val[1]) begin
          exp_gnt = !last_gnt;
          check("grant_client", 32'(acc_q[1]), 32'(exp_gnt));
        end
        last_gnt = acc_q[1];
      end
      for (int c = 0; c < 2; c++) begin
        if (resp_val[c] && resp_rdy[c]) begin
          if (exp_rd[c] == exp_wr[c]) begin
            $display("Client %0d got a response with no request outstanding", c);
            error_count++;
          end else begin
            l = exp_line[c][exp_rd[c]];
            exp_rd[c]++;
            check($sformatf("c%0d_resp_op", c), 32'(resp_op[c]), 32'(ln_op[l]));
            check($sformatf("c%0d_resp_addr", c), 32'(resp_addr[c]), 32'(ln_addr[l]));
            check($sformatf("c%0d_resp_len", c), 32'(resp_len[c]), 32'(ln_len[l]));
            check($sformatf("c%0d_resp_opq", c), 32'(resp_opq[c]), 32'(ln_opq[l]));
            if (ln_op[l] == MEM_READ) begin
              check($sformatf("c%0d_resp_data", c), resp_data[c], pred_data[l]);
              check("file_rdata", ln_rdata[l], pred_data[l]);
            end
            // Response shows after edge acc+DELAY and is taken at the next edge
            if (l == N_LINES - 1) begin
              check("probe_latency", 32'(cycles - acc_cyc[l]), 32'(DELAY + 1));
            end
            resp_count++;
          end
        end
      end
    end
  end

  // --------------------------------------------------
  // Sequence
  // --------------------------------------------------

  initial begin
    $readmemh("mem_subsys_testdata.txt", td);
    for (int i = 0; i < N_LINES; i++) begin
      ln_client[i] = int'(td[N_COLS*i][0]);
      ln_op[i]     = mem_op_e'(td[N_COLS*i+1][0]);
      ln_addr[i]   = td[N_COLS*i+2][ADDR_BITS-1:0];
      ln_len[i]    = td[N_COLS*i+3][LEN_BITS-1:0];
      ln_data[i]   = td[N_COLS*i+4];
      ln_opq[i]    = td[N_COLS*i+5][OPQ_BITS-1:0];
      ln_rdata[i]  = td[N_COLS*i+6];
      // Last line is held back for the latency probe
      if (i < N_LINES - 1) begin
        pend[ln_client[i]][pend_wr[ln_client[i]]] = i;
        pend_wr[ln_client[i]]++;
      end
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(posedge clk);
    phase = 1;
    wait (resp_count == N_LINES - 1);
    @(posedge clk);
    // Lone request with the server drained and ready held high
    pend[ln_client[N_LINES-1]][pend_wr[ln_client[N_LINES-1]]] = N_LINES - 1;
    pend_wr[ln_client[N_LINES-1]]++;
    phase = 2;
    wait (resp_count == N_LINES);
    @(posedge clk);
    $display("Checks: %0d  Errors: %0d  Responses: %0d", check_count, error_count, resp_count);
    if (error_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- mem_subsys_checker.sv
// Memory subsystem assertions
// Response hold under back-pressure, single grant, quiet outputs in reset

`timescale 1ns/100ps

module mem_subsys_checker import mem_msg_pkg::*; (
  input logic      clk,
  input logic      rst,
  input logic      c0_req_val,
  input logic      c0_req_rdy,
  input logic      c1_req_val,
  input logic      c1_req_rdy,
  input logic      c0_resp_val,
  input logic      c0_resp_rdy,
  input mem_op_e   c0_resp_op,
  input mem_addr_t c0_resp_addr,
  input mem_len_t  c0_resp_len,
  input mem_data_t c0_resp_data,
  input mem_opq_t  c0_resp_opq,
  input logic      c1_resp_val,
  input logic      c1_resp_rdy,
  input mem_op_e   c1_resp_op,
  input mem_addr_t c1_resp_addr,
  input mem_len_t  c1_resp_len,
  input mem_data_t c1_resp_data,
  input mem_opq_t  c1_resp_opq
);

  // --------------------------------------------------
  // Response handshake
  // --------------------------------------------------

  // Stalled response keeps valid and payload
  c0_resp_hold: assert property (@(posedge clk) disable iff (rst)
    c0_resp_val && !c0_resp_rdy |=> c0_resp_val &&
      $stable({c0_resp_op, c0_resp_addr, c0_resp_len, c0_resp_data, c0_resp_opq}))
    else $error("client 0 response changed while stalled");

  c1_resp_hold: assert property (@(posedge clk) disable iff (rst)
    c1_resp_val && !c1_resp_rdy |=> c1_resp_val &&
      $stable({c1_resp_op, c1_resp_addr, c1_resp_len, c1_resp_data, c1_resp_opq}))
    else $error("client 1 response changed while stalled");

  // --------------------------------------------------
  // Grant and reset
  // --------------------------------------------------

  // Ready for at most one client and never for an idle one while the other waits
  one_grant: assert property (@(posedge clk)
    !(c0_req_val && c1_req_val && c0_req_rdy && c1_req_rdy) &&
    !(c1_req_val && !c0_req_val && c0_req_rdy) &&
    !(c0_req_val && !c1_req_val && c1_req_rdy))
    else $error("ready given to both clients or to an idle client");

  // Second reset edge onward, state has been cleared by then
  reset_quiet: assert property (@(posedge clk)
    rst && $past(rst) |-> !c0_req_rdy && !c1_req_rdy && !c0_resp_val && !c1_resp_val)
    else $error("ready or response valid high during reset");

endmodule

bind mem_subsys_top mem_subsys_checker checker_i (.*);

//--- mem_subsys_top.sv
// Two-client memory subsystem
// Round-robin arbiter in front of a delayed-response memory server

`timescale 1ns/100ps

module mem_subsys_top import mem_cfg_pkg::*; import mem_msg_pkg::*; #(
  parameter int p_transac_delay = DEF_TRANSAC_DELAY,
  parameter int p_resp_depth    = DEF_RESP_DEPTH,
  parameter int p_mem_words     = DEF_MEM_WORDS
)(
  input  logic      clk,
  input  logic      rst,

  // Client 0 request
  input  logic      c0_req_val,
  output logic      c0_req_rdy,
  input  mem_op_e   c0_req_op,
  input  mem_addr_t c0_req_addr,
  input  mem_len_t  c0_req_len,
  input  mem_data_t c0_req_data,
  input  mem_opq_t  c0_req_opq,

  // Client 1 request
  input  logic      c1_req_val,
  output logic      c1_req_rdy,
  input  mem_op_e   c1_req_op,
  input  mem_addr_t c1_req_addr,
  input  mem_len_t  c1_req_len,
  input  mem_data_t c1_req_data,
  input  mem_opq_t  c1_req_opq,

  // Client 0 response
  output logic      c0_resp_val,
  input  logic      c0_resp_rdy,
  output mem_op_e   c0_resp_op,
  output mem_addr_t c0_resp_addr,
  output mem_len_t  c0_resp_len,
  output mem_data_t c0_resp_data,
  output mem_opq_t  c0_resp_opq,

  // Client 1 response
  output logic      c1_resp_val,
  input  logic      c1_resp_rdy,
  output mem_op_e   c1_resp_op,
  output mem_addr_t c1_resp_addr,
  output mem_len_t  c1_resp_len,
  output mem_data_t c1_resp_data,
  output mem_opq_t  c1_resp_opq
);

  // Shared bus between arbiter and server
  mem_if bus_if ();

  // Client ports match by name
  mem_req_arbiter arb_i (
    .bus (bus_if.client),
    .*
  );

  mem_server #(
    .p_transac_delay (p_transac_delay),
    .p_resp_depth    (p_resp_depth),
    .p_mem_words     (p_mem_words)
  ) server_i (
    .clk (clk),
    .rst (rst),
    .srv (bus_if.server)
  );

endmodule

//--- mem_req_arbiter.sv
// Two-client request arbiter
// Round-robin grant of two clients onto one memory bus, client index
// carried in the tag top bit, responses steered back by that bit

`timescale 1ns/100ps

module mem_req_arbiter import mem_cfg_pkg::*; import mem_msg_pkg::*; (
  input  logic      clk,
  input  logic      rst,

  // Client 0 request
  input  logic      c0_req_val,
  output logic      c0_req_rdy,
  input  mem_op_e   c0_req_op,
  input  mem_addr_t c0_req_addr,
  input  mem_len_t  c0_req_len,
  input  mem_data_t c0_req_data,
  input  mem_opq_t  c0_req_opq,

  // Client 1 request
  input  logic      c1_req_val,
  output logic      c1_req_rdy,
  input  mem_op_e   c1_req_op,
  input  mem_addr_t c1_req_addr,
  input  mem_len_t  c1_req_len,
  input  mem_data_t c1_req_data,
  input  mem_opq_t  c1_req_opq,

  // Client 0 response
  output logic      c0_resp_val,
  input  logic      c0_resp_rdy,
  output mem_op_e   c0_resp_op,
  output mem_addr_t c0_resp_addr,
  output mem_len_t  c0_resp_len,
  output mem_data_t c0_resp_data,
  output mem_opq_t  c0_resp_opq,

  // Client 1 response
  output logic      c1_resp_val,
  input  logic      c1_resp_rdy,
  output mem_op_e   c1_resp_op,
  output mem_addr_t c1_resp_addr,
  output mem_len_t  c1_resp_len,
  output mem_data_t c1_resp_data,
  output mem_opq_t  c1_resp_opq,

  // Shared bus towards the server
  mem_if.client     bus
);

  // Client that won the last completed transfer
  logic last_gnt_q;
  // Current grant, 0 or 1
  logic gnt;
  // Response owner taken from the tag
  logic resp_sel;

  // --------------------------------------------------
  // Request side
  // --------------------------------------------------

  // Lone requester wins, on contention the other one from last time
  always_comb begin
    if (c0_req_val && c1_req_val) begin
      gnt = ~last_gnt_q;
    end else begin
      gnt = c1_req_val;
    end
  end

  // Pointer moves only on an accepted transfer
  // Reset value 1 so client 0 goes first
  always_ff @(posedge clk) begin
    if (rst) begin
      last_gnt_q <= 1'b1;
    end else if (bus.req_val && bus.req_rdy) begin
      last_gnt_q <= gnt;
    end
  end

  assign bus.req_val  = c0_req_val || c1_req_val;
  assign bus.req_op   = gnt ? c1_req_op   : c0_req_op;
  assign bus.req_addr = gnt ? c1_req_addr : c0_req_addr;
  assign bus.req_len  = gnt ? c1_req_len  : c0_req_len;
  assign bus.req_data = gnt ? c1_req_data : c0_req_data;
  // Client index goes on top of the opaque
  assign bus.req_tag  = {gnt, gnt ? c1_req_opq : c0_req_opq};

  // Only the granted client sees ready
  assign c0_req_rdy = bus.req_rdy && !gnt;
  assign c1_req_rdy = bus.req_rdy && gnt;

  // --------------------------------------------------
  // Response side
  // --------------------------------------------------

  assign resp_sel = bus.resp_tag[OPQ_BITS];

  assign c0_resp_val = bus.resp_val && !resp_sel;
  assign c1_resp_val = bus.resp_val && resp_sel;

  // Payload fans out to both, valid tells who owns it
  assign c0_resp_op   = bus.resp_op;
  assign c0_resp_addr = bus.resp_addr;
  assign c0_resp_len  = bus.resp_len;
  assign c0_resp_data = bus.resp_data;
  assign c0_resp_opq  = bus.resp_tag[OPQ_BITS-1:0];

  assign c1_resp_op   = bus.resp_op;
  assign c1_resp_addr = bus.resp_addr;
  assign c1_resp_len  = bus.resp_len;
  assign c1_resp_data = bus.resp_data;
  assign c1_resp_opq  = bus.resp_tag[OPQ_BITS-1:0];

  // Owner's ready back to the server
  assign bus.resp_rdy = resp_sel ? c1_resp_rdy : c0_resp_rdy;

endmodule

//--- mem_server.sv
// Memory server
// Word memory behind a fixed-delay request pipeline, byte-count writes,
// response buffer and credit-limited request acceptance

`timescale 1ns/100ps

module mem_server import mem_cfg_pkg::*; import mem_msg_pkg::*; #(
  parameter int p_transac_delay = DEF_TRANSAC_DELAY,
  parameter int p_resp_depth    = DEF_RESP_DEPTH,
  parameter int p_mem_words     = DEF_MEM_WORDS
)(
  input  logic  clk,
  input  logic  rst,
  mem_if.server srv
);

  localparam int idx_w  = (p_mem_words > 1) ? $clog2(p_mem_words) : 1;
  localparam int cnt_w  = $clog2(p_resp_depth + 1);
  localparam int last   = p_transac_delay - 1;
  localparam int nbytes = DATA_BITS / 8;

  srv_state_e state_q;

  // Word storage, filled by writes only
  mem_data_t mem_q [p_mem_words];

  // Delay pipeline, stage 0 takes the accepted request
  logic [p_transac_delay-1:0] pl_val;
  mem_op_e   pl_op   [p_transac_delay];
  mem_addr_t pl_addr [p_transac_delay];
  mem_len_t  pl_len  [p_transac_delay];
  mem_data_t pl_data [p_transac_delay];
  mem_tag_t  pl_tag  [p_transac_delay];

  // Credit accounting
  logic [cnt_w-1:0] inflight_q;
  logic [cnt_w-1:0] fifo_count;
  logic [cnt_w:0]   credit_used;

  logic             req_fire;
  logic             ex_val;
  logic [idx_w-1:0] ex_idx;
  mem_data_t        ex_old;
  mem_data_t        ex_merged;
  mem_data_t        ex_result;

  // Idle only for the reset cycles
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= SRV_IDLE;
    end else begin
      state_q <= SRV_RUN;
    end
  end

  // --------------------------------------------------
  // Acceptance and delay pipeline
  // --------------------------------------------------

  assign req_fire = srv.req_val && srv.req_rdy;

  always_ff @(posedge clk) begin
    if (rst) begin
      pl_val <= '0;
    end else begin
      pl_val[0] <= req_fire;
      for (int i = 1; i < p_transac_delay; i++) begin
        pl_val[i] <= pl_val[i-1];
      end
    end
  end

  // Payload shifts every cycle, the valid bits say what counts
  always_ff @(posedge clk) begin
    pl_op[0]   <= srv.req_op;
    pl_addr[0] <= srv.req_addr;
    pl_len[0]  <= srv.req_len;
    pl_data[0] <= srv.req_data;
    pl_tag[0]  <= srv.req_tag;
    for (int i = 1; i < p_transac_delay; i++) begin
      pl_op[i]   <= pl_op[i-1];
      pl_addr[i] <= pl_addr[i-1];
      pl_len[i]  <= pl_len[i-1];
      pl_data[i] <= pl_data[i-1];
      pl_tag[i]  <= pl_tag[i-1];
    end
  end

  // --------------------------------------------------
  // Execute at the pipeline end
  // --------------------------------------------------

  assign ex_val = pl_val[last];
  // Word index, byte offset bits dropped
  assign ex_idx = pl_addr[last][idx_w+1:2];
  assign ex_old = mem_q[ex_idx];

  // Low len bytes from the request, rest kept
  always_comb begin
    ex_merged = ex_old;
    for (int b = 0; b < nbytes; b++) begin
      if (pl_len[last] == '0 || b < int'(pl_len[last])) begin
        ex_merged[8*b +: 8] = pl_data[last][8*b +: 8];
      end
    end
  end

  // Reads return the stored word, writes return what was stored
  assign ex_result = (pl_op[last] == MEM_READ) ? ex_old : ex_merged;

  always_ff @(posedge clk) begin
    if (ex_val && pl_op[last] == MEM_WRITE) begin
      mem_q[ex_idx] <= ex_merged;
    end
  end

  // --------------------------------------------------
  // Response buffer and credits
  // --------------------------------------------------

  mem_resp_fifo #(
    .p_depth   (p_resp_depth)
  ) resp_fifo_i (
    .clk       (clk),
    .rst       (rst),
    .push      (ex_val),
    .push_op   (pl_op[last]),
    .push_addr (pl_addr[last]),
    .push_len  (pl_len[last]),
    .push_data (ex_result),
    .push_tag  (pl_tag[last]),
    .pop       (srv.resp_val && srv.resp_rdy),
    .out_val   (srv.resp_val),
    .out_op    (srv.resp_op),
    .out_addr  (srv.resp_addr),
    .out_len   (srv.resp_len),
    .out_data  (srv.resp_data),
    .out_tag   (srv.resp_tag),
    .count     (fifo_count)
  );

  // Requests between acceptance and push
  always_ff @(posedge clk) begin
    if (rst) begin
      inflight_q <= '0;
    end else if (req_fire && !ex_val) begin
      inflight_q <= inflight_q + 1'b1;
    end else if (ex_val && !req_fire) begin
      inflight_q <= inflight_q - 1'b1;
    end
  end

  // Buffer space is reserved at acceptance, so a push always fits
  assign credit_used = {1'b0, inflight_q} + {1'b0, fifo_count};
  assign srv.req_rdy = (state_q == SRV_RUN) &&
                       (credit_used < (cnt_w + 1)'(p_resp_depth));

endmodule

//--- mem_resp_fifo.sv
// Response buffer
// Circular buffer of response messages, exports occupancy for credit logic

`timescale 1ns/100ps

module mem_resp_fifo import mem_cfg_pkg::*; import mem_msg_pkg::*; #(
  parameter  int p_depth = DEF_RESP_DEPTH,
  localparam int cnt_w   = $clog2(p_depth + 1)
)(
  input  logic             clk,
  input  logic             rst,

  // Write side, never pushed while full
  input  logic             push,
  input  mem_op_e          push_op,
  input  mem_addr_t        push_addr,
  input  mem_len_t         push_len,
  input  mem_data_t        push_data,
  input  mem_tag_t         push_tag,

  // Read side
  input  logic             pop,
  output logic             out_val,
  output mem_op_e          out_op,
  output mem_addr_t        out_addr,
  output mem_len_t         out_len,
  output mem_data_t        out_data,
  output mem_tag_t         out_tag,
  output logic [cnt_w-1:0] count
);

  localparam int ptr_w = (p_depth > 1) ? $clog2(p_depth) : 1;

  // Entry storage
  mem_op_e   op_q   [p_depth];
  mem_addr_t addr_q [p_depth];
  mem_len_t  len_q  [p_depth];
  mem_data_t data_q [p_depth];
  mem_tag_t  tag_q  [p_depth];

  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [cnt_w-1:0] count_q;
  logic             do_pop;

  // Wrap at depth, which need not be a power of two
  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    if (ptr == ptr_w'(p_depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Pop of an empty buffer is ignored
  assign do_pop = pop && out_val;

  // --------------------------------------------------
  // Pointers and occupancy
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      // Simultaneous push and pop leaves count alone
      if (push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Payload write
  always_ff @(posedge clk) begin
    if (push) begin
      op_q[wr_ptr_q]   <= push_op;
      addr_q[wr_ptr_q] <= push_addr;
      len_q[wr_ptr_q]  <= push_len;
      data_q[wr_ptr_q] <= push_data;
      tag_q[wr_ptr_q]  <= push_tag;
    end
  end

  // Head of queue straight to the port
  assign out_val  = (count_q != '0);
  assign out_op   = op_q[rd_ptr_q];
  assign out_addr = addr_q[rd_ptr_q];
  assign out_len  = len_q[rd_ptr_q];
  assign out_data = data_q[rd_ptr_q];
  assign out_tag  = tag_q[rd_ptr_q];
  assign count    = count_q;

endmodule

//--- mem_if.sv
// Memory bus interface
// One request/response channel with valid/ready on each direction

`timescale 1ns/100ps

interface mem_if import mem_msg_pkg::*; ();

  // Request, client to server
  logic      req_val;
  logic      req_rdy;
  mem_op_e   req_op;
  mem_addr_t req_addr;
  mem_len_t  req_len;
  mem_data_t req_data;
  mem_tag_t  req_tag;

  // Response, server to client
  logic      resp_val;
  logic      resp_rdy;
  mem_op_e   resp_op;
  mem_addr_t resp_addr;
  mem_len_t  resp_len;
  mem_data_t resp_data;
  mem_tag_t  resp_tag;

  // Requesting side
  modport client (
    output req_val, req_op, req_addr, req_len, req_data, req_tag, resp_rdy,
    input  req_rdy, resp_val, resp_op, resp_addr, resp_len, resp_data, resp_tag
  );

  // Answering side
  modport server (
    input  req_val, req_op, req_addr, req_len, req_data, req_tag, resp_rdy,
    output req_rdy, resp_val, resp_op, resp_addr, resp_len, resp_data, resp_tag
  );

endinterface

//--- mem_msg_pkg.sv
// Memory message types
// Field typedefs for request/response messages, op codes and server states

package mem_msg_pkg;

  import mem_cfg_pkg::*;

  // --------------------------------------------------
  // Message fields
  // --------------------------------------------------

  // Byte address, low two bits select the byte in a word
  typedef logic [ADDR_BITS-1:0] mem_addr_t;

  // Data word
  typedef logic [DATA_BITS-1:0] mem_data_t;

  // Byte count, 0 means all four bytes
  typedef logic [LEN_BITS-1:0] mem_len_t;

  // Opaque value owned by a client
  typedef logic [OPQ_BITS-1:0] mem_opq_t;

  // Internal opaque on the shared bus
  // Top bit carries the client index, the rest is the client opaque
  typedef logic [OPQ_BITS:0] mem_tag_t;

  // --------------------------------------------------
  // Encodings
  // --------------------------------------------------

  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_op_e;

  // Server comes out of reset idle, then runs
  typedef enum logic {
    SRV_IDLE = 1'b0,
    SRV_RUN  = 1'b1
  } srv_state_e;

endpackage

//--- mem_cfg_pkg.sv
// Memory subsystem configuration
// Field widths and default sizing for the two-client memory subsystem

package mem_cfg_pkg;

  // --------------------------------------------------
  // Message field widths
  // --------------------------------------------------

  // Byte address
  localparam int ADDR_BITS = 16;
  // One data word, four bytes
  localparam int DATA_BITS = 32;
  // Byte count of a write, 0 stands for a full word
  localparam int LEN_BITS  = 2;
  // Opaque field as seen by one client
  localparam int OPQ_BITS  = 8;

  // --------------------------------------------------
  // Default parameter values
  // --------------------------------------------------

  localparam int DEF_TRANSAC_DELAY = 1;
  localparam int DEF_RESP_DEPTH    = 4;
  localparam int DEF_MEM_WORDS     = 256;

endpackage
